//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int word_size   = 16;  // data and address width
    localparam int num_regs    = 8;
    localparam int reg_bits    = 3;
    localparam int opcode_bits = 3;
    localparam int imm_bits    = 9;   // signed immediate in bits 8..0
    localparam int pc_reg      = 7;   // r7 is the program counter

    typedef logic [word_size-1:0] word_t;
    typedef logic [reg_bits-1:0]  reg_idx_t;

    // bits 15..13 of the instruction word
    typedef enum logic [opcode_bits-1:0] {
        op_mov, op_branch, op_add, op_sub,
        op_ld, op_st, op_and, op_other
    } opcode_t;

    typedef enum logic [2:0] {
        i_nop, i_mov, i_add, i_sub, i_load, i_store, i_cmp, i_branch
    } instr_t;

    typedef enum logic [1:0] {
        alu_none, alu_mov, alu_add, alu_sub
    } alu_op_t;

    // branch condition sits in the rX field
    typedef enum logic [2:0] {
        c_none = 3'd0,
        c_eq   = 3'd1,
        c_ne   = 3'd2,
        c_cc   = 3'd3,
        c_cs   = 3'd4,
        c_pl   = 3'd5,
        c_mi   = 3'd6
    } cond_t;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } flags_t;

    typedef struct packed {
        word_t    op1;           // rX value, store data, or branch address
        word_t    op2;           // rY value or immediate, memory address
        word_t    out;           // result travelling to writeback
        reg_idx_t rx;
        reg_idx_t ry;
        logic     imm;           // op2 came from the immediate field
        logic     writeback;     // out goes into rx
        logic     read;
        logic     write;
        logic     update_flags;
        instr_t   instr;
        alu_op_t  alu_op;
        cond_t    cond;
    } pipe_entry_t;

    localparam pipe_entry_t bubble = '0;  // all clear, instr is i_nop

endpackage

`default_nettype wire

//--- source/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile import cpu_pkg::*; (
    input  logic     Clock,
    input  logic     Reset,
    input  reg_idx_t rd_a_idx,
    input  reg_idx_t rd_b_idx,
    output word_t    rd_a,
    output word_t    rd_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    input  word_t    pc_next,
    input  logic     pc_load,
    output word_t    pc
);

    word_t regs [num_regs];

    assign rd_a = regs[rd_a_idx];
    assign rd_b = regs[rd_b_idx];
    assign pc   = regs[pc_reg];

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
            regs[pc_reg] <= '1;  // fetch address is pc + 1, so first fetch at 0
        end else begin
            if (pc_load) begin
                regs[pc_reg] <= pc_next;
            end
            // writeback comes last so a branch result overrides the fetch update
            if (wr_en) begin
                regs[wr_idx] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decoder import cpu_pkg::*; (
    input  word_t       fetched,
    output reg_idx_t    rd_a_idx,
    output reg_idx_t    rd_b_idx,
    input  word_t       rd_a,
    input  word_t       rd_b,
    input  word_t       pc,
    output pipe_entry_t decoded
);

    // immediate form:  ooo i xxx ddddddddd
    // register form:   ooo i xxx 000000 yyy
    opcode_t  opcode;
    logic     imm_flag;
    reg_idx_t rx_field;
    word_t    imm_ext;

    assign opcode   = opcode_t'(fetched[word_size-1 -: opcode_bits]);
    assign imm_flag = fetched[word_size-opcode_bits-1];
    assign rx_field = fetched[word_size-opcode_bits-2 -: reg_bits];
    assign imm_ext  = {{(word_size-imm_bits){fetched[imm_bits-1]}}, fetched[imm_bits-1:0]};

    assign rd_a_idx = rx_field;
    assign rd_b_idx = fetched[reg_bits-1:0];

    always_comb begin
        decoded           = bubble;
        decoded.rx        = rx_field;
        decoded.ry        = rd_b_idx;
        decoded.imm       = imm_flag;
        decoded.writeback = 1'b1;
        decoded.op1       = rd_a;
        decoded.op2       = imm_flag ? imm_ext : rd_b;

        case (opcode)
            op_mov: begin
                decoded.instr  = i_mov;
                decoded.alu_op = alu_mov;
            end
            op_add: begin
                decoded.instr  = i_add;
                decoded.alu_op = alu_add;
            end
            op_sub: begin
                decoded.instr  = i_sub;
                decoded.alu_op = alu_sub;
            end
            op_ld: begin
                decoded.instr = i_load;
                decoded.read  = 1'b1;
            end
            op_st: begin
                decoded.instr     = i_store;
                decoded.write     = 1'b1;
                decoded.writeback = 1'b0;  // rX is the store data
            end
            op_branch: begin
                // imm set would be mvt, which stays a nop
                if (!imm_flag) begin
                    decoded.instr  = i_branch;
                    decoded.alu_op = alu_add;   // own address + offset
                    decoded.rx     = reg_idx_t'(pc_reg);
                    decoded.op1    = pc;
                    decoded.op2    = imm_ext;
                    decoded.imm    = 1'b1;      // no rY source
                    decoded.cond   = (rx_field == '1) ? c_none : cond_t'(rx_field);
                end
            end
            op_other: begin
                if (imm_flag || fetched[imm_bits-1:reg_bits] == '0) begin
                    decoded.instr        = i_cmp;
                    decoded.alu_op       = alu_sub;
                    decoded.update_flags = 1'b1;
                    decoded.writeback    = 1'b0;
                end
            end
            default: begin
            end
        endcase

        // zero word, and/logic and anything left undecoded
        if (fetched == '0 || decoded.instr == i_nop) begin
            decoded = bubble;
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_hazard.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_hazard import cpu_pkg::*; (
    input  pipe_entry_t decoded,
    input  pipe_entry_t ex_entry,
    input  pipe_entry_t mem1_entry,
    input  pipe_entry_t mem2_entry,
    input  pipe_entry_t wb_entry,
    output logic        decode_stall
);

    pipe_entry_t later [4];  // everything past decode, oldest last

    assign later[0] = ex_entry;
    assign later[1] = mem1_entry;
    assign later[2] = mem2_entry;
    assign later[3] = wb_entry;

    always_comb begin
        decode_stall = 1'b0;
        for (int i = 0; i < 4; i++) begin
            // branch in flight, pc not final yet
            if (later[i].instr == i_branch) begin
                decode_stall = 1'b1;
            end
            if (decoded.instr != i_nop && later[i].writeback) begin
                if (later[i].rx == decoded.rx) begin
                    decode_stall = 1'b1;  // rX is source and destination
                end
                if (!decoded.imm && later[i].rx == decoded.ry) begin
                    decode_stall = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute import cpu_pkg::*; (
    input  pipe_entry_t entry,
    input  flags_t      flags,
    output pipe_entry_t result,
    output flags_t      next_flags,
    output logic        taken
);

    logic [word_size:0] alu_ext;  // top bit is carry, or borrow for sub
    logic               cond_met;

    always_comb begin
        case (entry.alu_op)
            alu_mov: alu_ext = {1'b0, entry.op2};
            alu_add: alu_ext = {1'b0, entry.op1} + {1'b0, entry.op2};
            alu_sub: alu_ext = {1'b0, entry.op1} - {1'b0, entry.op2};
            default: alu_ext = {1'b0, entry.out};  // ld/st pass through
        endcase
    end

    always_comb begin
        case (entry.cond)
            c_eq:    cond_met = flags.zero;
            c_ne:    cond_met = !flags.zero;
            c_cc:    cond_met = !flags.carry;
            c_cs:    cond_met = flags.carry;
            c_pl:    cond_met = !flags.zero && !flags.negative;
            c_mi:    cond_met = !flags.zero && flags.negative;
            default: cond_met = 1'b1;
        endcase
    end

    assign taken = cond_met && (entry.instr == i_branch);

    always_comb begin
        result     = entry;
        result.out = alu_ext[word_size-1:0];
        next_flags = flags;
        if (!cond_met) begin
            result = bubble;  // failed branch drops out here
        end else if (entry.update_flags) begin
            next_flags.negative = alu_ext[word_size-1];
            next_flags.zero     = (alu_ext[word_size-1:0] == '0);
            next_flags.carry    = alu_ext[word_size];
            // operands of different sign and result sign flipped from op1
            next_flags.overflow = (entry.alu_op == alu_sub)
                && (entry.op1[word_size-1] != entry.op2[word_size-1])
                && (alu_ext[word_size-1] != entry.op1[word_size-1]);
        end
    end

endmodule

`default_nettype wire

//--- source/cpu_memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_memory_stage import cpu_pkg::*; (
    input  logic        Clock,
    input  logic        Reset,
    input  pipe_entry_t from_execute,  // entry in memory1
    output pipe_entry_t mem1_out,      // entry in memory2
    output pipe_entry_t to_writeback,
    input  word_t       data_in,
    input  logic        data_done,
    output word_t       data_addr,
    output word_t       data_out,
    output logic        data_read,
    output logic        data_write,
    output logic        mem_stall
);

    pipe_entry_t mem1_q;
    pipe_entry_t mem2_q;
    logic        request;

    assign request = from_execute.read || from_execute.write;

    // upstream freezes from_execute, so the request holds until done
    assign data_read  = from_execute.read;
    assign data_write = from_execute.write;
    assign data_addr  = request ? from_execute.op2 : '0;
    assign data_out   = from_execute.write ? from_execute.op1 : '0;  // rX value

    assign mem_stall = request && !data_done;

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            mem1_q <= bubble;
            mem2_q <= bubble;
        end else begin
            mem2_q <= mem1_q;  // never held, writeback keeps draining
            if (mem_stall) begin
                mem1_q <= bubble;
            end else begin
                mem1_q <= from_execute;
                if (from_execute.read) begin
                    mem1_q.out <= data_in;  // load data sampled with done
                end
            end
        end
    end

    assign mem1_out     = mem1_q;
    assign to_writeback = mem2_q;

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  logic  Clock,
    input  logic  Reset,
    input  word_t instr_in,
    input  word_t data_in,
    input  logic  data_done,
    output word_t instr_addr,
    output word_t data_addr,
    output word_t data_out,
    output logic  data_read,
    output logic  data_write
);

    word_t       fetch_q;      // fetched word, decoded this cycle
    pipe_entry_t dec_q;        // entry in execute
    pipe_entry_t ex_q;         // entry in memory1
    pipe_entry_t mem1_out;     // entry in memory2
    pipe_entry_t wb_entry;     // entry in writeback
    flags_t      flags_q;
    flags_t      next_flags;
    logic        redirect_q;   // taken branch in flight, fetch_q is off-path

    word_t       dec_word;
    reg_idx_t    rd_a_idx;
    reg_idx_t    rd_b_idx;
    word_t       rd_a;
    word_t       rd_b;
    word_t       pc;
    pipe_entry_t decoded;
    pipe_entry_t exec_result;
    logic        taken;
    logic        mem_stall;
    logic        decode_stall;
    logic        fetch_advance;

    assign fetch_advance = !mem_stall && !decode_stall;

    // pc holds the last fetched address; after a branch it holds the target
    assign instr_addr = redirect_q ? pc : pc + word_t'(1);
    assign dec_word   = redirect_q ? '0 : fetch_q;

    cpu_regfile i_regfile (
        .Clock    (Clock),
        .Reset    (Reset),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr_en    (wb_entry.writeback),
        .wr_idx   (wb_entry.rx),
        .wr_data  (wb_entry.out),
        .pc_next  (instr_addr),      // increment, or hold on redirect
        .pc_load  (fetch_advance),
        .pc       (pc)
    );

    cpu_decoder i_decoder (
        .fetched  (dec_word),
        .rd_a_idx (rd_a_idx),
        .rd_b_idx (rd_b_idx),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .pc       (pc),
        .decoded  (decoded)
    );

    cpu_hazard i_hazard (
        .decoded      (decoded),
        .ex_entry     (dec_q),
        .mem1_entry   (ex_q),
        .mem2_entry   (mem1_out),
        .wb_entry     (wb_entry),
        .decode_stall (decode_stall)
    );

    cpu_execute i_execute (
        .entry      (dec_q),
        .flags      (flags_q),
        .result     (exec_result),
        .next_flags (next_flags),
        .taken      (taken)
    );

    cpu_memory_stage i_memory_stage (
        .Clock        (Clock),
        .Reset        (Reset),
        .from_execute (ex_q),
        .mem1_out     (mem1_out),
        .to_writeback (wb_entry),
        .data_in      (data_in),
        .data_done    (data_done),
        .data_addr    (data_addr),
        .data_out     (data_out),
        .data_read    (data_read),
        .data_write   (data_write),
        .mem_stall    (mem_stall)
    );

    always_ff @(posedge Clock, posedge Reset) begin
        if (Reset) begin
            fetch_q    <= '0;
            dec_q      <= bubble;
            ex_q       <= bubble;
            flags_q    <= '0;
            redirect_q <= 1'b0;
        end else if (!mem_stall) begin  // back-pressure freezes everything up to memory1
            ex_q    <= exec_result;
            flags_q <= next_flags;
            dec_q   <= decode_stall ? bubble : decoded;
            if (!decode_stall) begin
                fetch_q <= instr_in;
            end
            if (taken) begin
                redirect_q <= 1'b1;
            end else if (!decode_stall) begin
                redirect_q <= 1'b0;  // refetch at the target happened
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int prog_words  = 64;
    localparam int cycle_limit = 3000;  // 64 instructions at up to 30 cycles, plus slack
    localparam int wait_slots  = 256;

    typedef struct packed {
        logic  write;
        word_t addr;
        word_t data;
    } access_t;

    logic  Clock;
    logic  Reset;
    word_t instr_in;
    word_t data_in;
    logic  data_done;
    word_t instr_addr;
    word_t data_addr;
    word_t data_out;
    logic  data_read;
    logic  data_write;

    word_t   prog [prog_words];
    word_t   dmem [65536];
    word_t   m_dmem [65536];     // model's own data memory
    access_t exp_q [$];          // expected accesses in program order
    int      wait_tab [wait_slots];
    int      wait_left;          // wait cycles left for the next access
    int      n_access;
    logic    pending;            // a request is waiting for done
    access_t held;
    int      cycles;
    word_t   prev_addr;
    logic    end_seen;

    cpu_core i_cpu_core (
        .Clock      (Clock),
        .Reset      (Reset),
        .instr_in   (instr_in),
        .data_in    (data_in),
        .data_done  (data_done),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .data_out   (data_out),
        .data_read  (data_read),
        .data_write (data_write)
    );

    always #5 Clock = ~Clock;

    // both memories answer in the same cycle
    assign instr_in = (instr_addr < word_t'(prog_words)) ? prog[instr_addr[5:0]] : '0;
    assign data_in  = dmem[data_addr];

    function automatic word_t fill_value(int unsigned addr);
        return word_t'(addr * 32'h2f1b) ^ 16'h6c35;
    endfunction

    function automatic word_t encode(opcode_t op, logic imm, int rx, logic [8:0] low);
        return {op, imm, 3'(rx), low};
    endfunction

    function automatic word_t operand_form(opcode_t op, logic use_imm, int rx, int ry,
                                           logic [8:0] imm9);
        if (use_imm) begin
            return encode(op, 1'b1, rx, imm9);
        end
        return encode(op, 1'b0, rx, 9'(ry));  // bits 8..3 stay zero
    endfunction

    // branch condition from the rX field, 0 and 7 mean always
    function automatic logic cond_holds(logic [2:0] field, flags_t f);
        case (field)
            3'd1:    return f.zero;
            3'd2:    return !f.zero;
            3'd3:    return !f.carry;
            3'd4:    return f.carry;
            3'd5:    return !f.zero && !f.negative;
            3'd6:    return !f.zero && f.negative;
            default: return 1'b1;
        endcase
    endfunction

    task automatic report_failure(string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("ERR time=%0t %s expected=%h actual=%h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_access(string name, logic exp_read, logic exp_write, word_t exp_addr,
                                logic act_read, logic act_write, word_t act_addr);
        if (act_read !== exp_read || act_write !== exp_write || act_addr !== exp_addr) begin
            report_failure($sformatf(
                "ERR time=%0t %s expected read=%b write=%b addr=%h actual read=%b write=%b addr=%h",
                $time, name, exp_read, exp_write, exp_addr, act_read, act_write, act_addr));
        end
    endtask

    task automatic build_program();
        int         kind;
        int         rx;
        int         ry;
        int         room;
        logic       use_imm;
        logic [8:0] imm9;
        logic [8:0] addr9;
        for (int i = 0; i < prog_words - 1; i++) begin
            kind    = $urandom % 20;
            rx      = $urandom % 7;  // r7 is the pc
            ry      = $urandom % 7;
            use_imm = $urandom % 2;
            addr9   = 9'($urandom % 32);
            if ($urandom % 4 == 0) begin
                imm9 = 9'($urandom);
            end else begin
                imm9 = 9'($urandom % 8) - 9'd4;  // small values so eq and ne both happen
            end
            if (kind < 3) begin
                prog[i] = operand_form(op_mov, use_imm, rx, ry, imm9);
            end else if (kind < 6) begin
                prog[i] = operand_form(op_add, use_imm, rx, ry, imm9);
            end else if (kind < 9) begin
                prog[i] = operand_form(op_sub, use_imm, rx, ry, imm9);
            end else if (kind < 11) begin
                prog[i] = operand_form(op_ld, use_imm, rx, ry, addr9);
            end else if (kind < 15) begin
                prog[i] = operand_form(op_st, use_imm, rx, ry, addr9);
            end else if (kind < 17) begin
                prog[i] = operand_form(op_other, use_imm, rx, ry, imm9);  // cmp
            end else begin
                room    = (prog_words - 1 - i < 4) ? prog_words - 1 - i : 4;
                prog[i] = encode(op_branch, 1'b0, $urandom % 8, 9'(1 + $urandom % room));
            end
        end
        prog[prog_words-1] = encode(op_branch, 1'b0, 0, 9'd0);  // self-branch, always
    endtask

    // sequential ISA model, fills exp_q
    task automatic run_model();
        word_t              r [num_regs];
        flags_t             fl;
        int                 pc;
        int                 next_pc;
        word_t              w;
        word_t              opnd;
        reg_idx_t           rx;
        logic [word_size:0] diff;
        for (int i = 0; i < num_regs; i++) begin
            r[i] = '0;
        end
        fl = '0;
        pc = 0;
        while (pc < prog_words - 1) begin
            w       = prog[pc];
            rx      = w[11:9];
            opnd    = w[12] ? {{7{w[8]}}, w[8:0]} : r[w[2:0]];
            next_pc = pc + 1;
            case (opcode_t'(w[15:13]))
                op_mov: r[rx] = opnd;
                op_add: r[rx] = r[rx] + opnd;
                op_sub: r[rx] = r[rx] - opnd;
                op_ld: begin
                    exp_q.push_back({1'b0, opnd, word_t'(0)});
                    r[rx] = m_dmem[opnd];
                end
                op_st: begin
                    exp_q.push_back({1'b1, opnd, r[rx]});
                    m_dmem[opnd] = r[rx];
                end
                op_other: begin
                    if (w[12] || w[8:3] == '0) begin
                        diff        = {1'b0, r[rx]} - {1'b0, opnd};
                        fl.negative = diff[15];
                        fl.zero     = (diff[15:0] == '0);
                        fl.carry    = diff[16];  // borrow
                        fl.overflow = (r[rx][15] != opnd[15]) && (diff[15] != r[rx][15]);
                    end
                end
                op_branch: begin
                    if (!w[12] && cond_holds(w[11:9], fl)) begin
                        next_pc = pc + int'(w[8:0]);
                    end
                end
                default: begin
                end
            endcase
            pc = next_pc;
        end
    endtask

    initial begin
        int unsigned first_draw;
        first_draw = $urandom(34);
        Clock      = 1'b0;
        Reset      = 1'b1;
        data_done  = 1'b0;
        pending    = 1'b0;
        cycles     = 0;
        prev_addr  = '0;
        end_seen   = 1'b0;
        for (int a = 0; a < 65536; a++) begin
            dmem[a]   = fill_value(a);
            m_dmem[a] = fill_value(a);
        end
        build_program();
        run_model();
        for (int i = 0; i < wait_slots; i++) begin
            wait_tab[i] = $urandom % 4;
        end
        wait_left = wait_tab[0];
        n_access  = 1;
        data_done = (wait_left == 0);  // memory may be ready before the first request
        repeat (3) @(posedge Clock);
        Reset <= 1'b0;
        @(posedge Clock);  // sampled values belong to the first cycle after reset
        check_word("instr_addr", '0, instr_addr);
        check_access("data port", 1'b0, 1'b0, '0, data_read, data_write, data_addr);
        wait (end_seen);
        if (exp_q.size() != 0) begin
            report_failure($sformatf("final branch reached with %0d data accesses missing",
                                     exp_q.size()));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    // data memory, access checks and end detection
    always @(posedge Clock) begin
        access_t exp;
        if (!Reset) begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                report_failure($sformatf("timeout, final branch not reached in %0d cycles",
                                         cycle_limit));
            end
            if (pending) begin  // request must hold still until done
                check_access("data port", !held.write, held.write, held.addr,
                             data_read, data_write, data_addr);
                if (held.write) begin
                    check_word("data_out", held.data, data_out);
                end
            end
            if (data_read || data_write) begin
                if (data_done) begin
                    if (exp_q.size() == 0) begin
                        report_failure("processor made a data access that the model does not make");
                    end else begin
                        exp = exp_q.pop_front();
                        check_access("data port", !exp.write, exp.write, exp.addr,
                                     data_read, data_write, data_addr);
                        if (exp.write) begin
                            check_word("data_out", exp.data, data_out);
                            dmem[data_addr] <= data_out;
                        end
                    end
                    pending   = 1'b0;
                    wait_left = wait_tab[n_access % wait_slots];
                    n_access  = n_access + 1;
                end else begin
                    pending   = 1'b1;
                    held      = {data_write, data_addr, data_out};
                    wait_left = wait_left - 1;
                end
                data_done <= (wait_left == 0);
            end
            // self-branch: fetch runs to pc + 1, then comes back to its own address
            if (prev_addr == word_t'(prog_words) && instr_addr == word_t'(prog_words - 1)) begin
                end_seen = 1'b1;
            end
            prev_addr = instr_addr;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
source/cpu_pkg.sv
source/cpu_regfile.sv
source/cpu_decoder.sv
source/cpu_hazard.sv
source/cpu_execute.sv
source/cpu_memory_stage.sv
source/cpu_core.sv
sim/cpu_tb.sv
